//--- move_vectors.txt
# op dir | 16 load tiles (L only) | 16 expected tiles | expected score, tiles decimal
# tile order r*4+c, row 0 bottom, column 3 left; dir bits: left down up right
L 0000 2 0 2 4 0 0 0 0 2 2 2 2 0 8 4 4  2 0 2 4 0 0 0 0 2 2 2 2 0 8 4 4  0
M 1000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 4 4 0 0 0 0 0 0 4 4 0 0 8 8  20
M 0100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 8 8 0 0 8 8 0 0 0 0 0 0 0 0  36
M 0001 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  16 0 0 0 16 0 0 0 0 0 0 0 0 0 0 0  68
M 0010 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 32 0 0 0  100
M 0010 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 32 0 0 0  100
M 0110 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 32 0 0 0  100
L 0000 8 2 0 0 8 0 0 0 8 2 0 0 0 4 0 0  8 2 0 0 8 0 0 0 8 2 0 0 0 4 0 0  0
M 0100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  16 4 0 0 8 4 0 0 0 0 0 0 0 0 0 0  20
X 1000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 16 4 0 0 8 4 0 0 0 0 0 0 0 0  20
M 0100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 16 8 0 0 8 0 0 0 0 0 0 0 0 0  28
R 1000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
L 0000 2 2 2 0 0 0 0 0 0 4 0 4 0 0 0 0  2 2 2 0 0 0 0 0 0 4 0 4 0 0 0 0  0
M 0001 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  4 2 0 0 0 0 0 0 8 0 0 0 0 0 0 0  12

//--- sim.f
game_pkg.sv
step_if.sv
board_regs.sv
tile_shift.sv
summation.sv
move_ctrl.sv
game_2048_top.sv
game_sva.sv
tb_game_2048.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_game_2048 -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_game_2048)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1

//--- tb_game_2048.sv
/*
 Testbench for the 2048 move engine, stimulus and expected results from move_vectors.txt.
 Ops: L load, M move, X move plus an opposite move pulse while busy, R reset in a move.
 A move whose direction is not one-hot must give no done for 20 cycles.
 Run from the project root so the vector file is found.
*/
`default_nettype none

module tb_game_2048 import game_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int score_w = 20;
	localparam int cells   = board_n*board_n;
	localparam int board_w = cells*tile_w; // Flat board bus

	logic               clk;
	logic               reset;
	logic               load;
	logic [board_w-1:0] board_in;
	logic               move;
	logic [3:0]         dir;
	logic               busy;
	logic               done;
	logic [board_w-1:0] board_out;
	logic [score_w-1:0] score;

	byte                op_q[$]; // One entry per vector line
	logic [3:0]         dir_q[$];
	logic [board_w-1:0] in_q[$];
	logic [board_w-1:0] exp_q[$];
	int                 score_q[$];

	int check_errors = 0;
	int other_errors = 0;
	int cycles       = 0;
	int cycle_limit  = 100; // Raised once the vectors are known

	game_2048_top #(
		.SCORE_W(score_w)
	) dut_i (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.board_in (board_in),
		.move     (move),
		.dir      (dir),
		.busy     (busy),
		.done     (done),
		.board_out(board_out),
		.score    (score)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	// Closing count line and verdict
	task automatic end_run();
		$display("Errors: %0d check, %0d other", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
			other_errors++;
			end_run();
		end
	end

	task automatic read_vectors();
		int                 fd;
		int                 n;
		int                 v;
		byte                op;
		logic [3:0]         d;
		logic [board_w-1:0] b_in;
		logic [board_w-1:0] b_exp;
		logic [8*128-1:0]   rest;
		fd = $fopen("move_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open move_vectors.txt");
			other_errors++;
			return;
		end
		while ($fscanf(fd, " %c", op) == 1) begin
			if (op == "#") begin
				n = $fgets(rest, fd); // Column notes
			end else begin
				n = $fscanf(fd, "%b", d);
				for (int k = 0; k < 2*cells; k++) begin
					n = $fscanf(fd, "%d", v);
					if (k < cells) b_in[k*tile_w +: tile_w] = v[tile_w-1:0];
					else b_exp[(k-cells)*tile_w +: tile_w] = v[tile_w-1:0];
				end
				n = $fscanf(fd, "%d", v); // Expected score
				op_q.push_back(op);
				dir_q.push_back(d);
				in_q.push_back(b_in);
				exp_q.push_back(b_exp);
				score_q.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_result(input int idx, input logic [board_w-1:0] exp_b, input int exp_s);
		if (board_out !== exp_b) begin
			$display("CHECK FAILED at %0t: vector %0d board %h expected %h",
				$time, idx, board_out, exp_b);
			check_errors++;
		end
		if (score !== score_w'(exp_s)) begin
			$display("CHECK FAILED at %0t: vector %0d score %0d expected %0d",
				$time, idx, score, exp_s);
			check_errors++;
		end
	endtask

	task automatic load_board(input logic [board_w-1:0] b);
		@(posedge clk);
		load     <= 1'b1;
		board_in <= b;
		@(posedge clk);
		load     <= 1'b0;
		@(negedge clk); // Board shows one cycle after the load edge
	endtask

	task automatic pulse_move(input logic [3:0] d);
		@(posedge clk);
		move <= 1'b1;
		dir  <= d;
		@(posedge clk);
		move <= 1'b0;
	endtask

	task automatic wait_done(input int idx);
		@(negedge clk);
		if (!busy) begin
			$display("CHECK FAILED at %0t: vector %0d busy low during the move", $time, idx);
			check_errors++;
		end
		while (!done) @(negedge clk); // Hang caught by the cycle counter
		if (busy) begin
			$display("CHECK FAILED at %0t: vector %0d busy high with done", $time, idx);
			check_errors++;
		end
	endtask

	task automatic run_vector(input int i);
		case (op_q[i])
			"L": load_board(in_q[i]);
			"M": begin
				pulse_move(dir_q[i]);
				if ($onehot(dir_q[i])) begin
					wait_done(i);
				end else begin
					repeat (20) begin
						@(negedge clk);
						if (done || busy) begin
							$display("CHECK FAILED at %0t: vector %0d move started with direction %b",
								$time, i, dir_q[i]);
							check_errors++;
						end
					end
				end
			end
			"X": begin
				pulse_move(dir_q[i]);
				// Opposite direction while busy is dropped
				pulse_move({dir_q[i][0], dir_q[i][1], dir_q[i][2], dir_q[i][3]});
				wait_done(i);
			end
			"R": begin
				pulse_move(dir_q[i]);
				@(posedge clk);
				reset <= 1'b1; // Lands in the middle of the move
				repeat (2) @(posedge clk);
				reset <= 1'b0;
				@(negedge clk);
				if (busy) begin
					$display("CHECK FAILED at %0t: vector %0d busy high after reset", $time, i);
					check_errors++;
				end
			end
			default: begin
				$display("Vector %0d has an unknown op code %c", i, op_q[i]);
				other_errors++;
			end
		endcase
		check_result(i, exp_q[i], score_q[i]);
	endtask

	initial begin
		reset    = 1'b1;
		load     = 1'b0;
		move     = 1'b0;
		dir      = '0;
		board_in = '0;
		void'($urandom(32'hef05));
		read_vectors();
		cycle_limit = op_q.size()*40 + 100;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		foreach (op_q[i]) begin
			repeat ($urandom_range(3)) @(posedge clk); // Idle gap between operations
			run_vector(i);
		end
		end_run();
	end

endmodule

`default_nettype wire

//--- game_sva.sv
/*
 Assertions on the move FSM strobes and state.
 Bound into every move_ctrl and only active with assertions enabled.
*/
`default_nettype none

module game_sva import game_pkg::*; (
	input logic        clk,
	input logic        reset,
	input ctrl_state_t state,
	input logic        move,
	input dir_t        dir_in,
	input logic        busy,
	input logic        done,
	input logic        take_shift,
	input logic        take_sum
);

	timeunit 1ns;
	timeprecision 1ps;

	// Done follows the last board write-back of a move
	done_after_wb: assert property (@(posedge clk) disable iff (reset)
		done |-> ($past(state) == merge_wb || $past(state) == reshift_wb))
		else $error("done without a write-back in the cycle before");

	done_one_cycle: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done longer than one cycle");

	// A move starts only from a one-hot request
	start_valid: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> ($past(move) && $onehot($past(dir_in))))
		else $error("busy rose without a valid move request");

	idle_after_reset: assert property (@(posedge clk)
		reset |=> !busy)
		else $error("busy high in the cycle after reset");

endmodule

bind move_ctrl game_sva sva_i (
	.clk       (clk),
	.reset     (reset),
	.state     (state),
	.move      (move),
	.dir_in    (dir_in),
	.busy      (busy),
	.done      (done),
	.take_shift(take_shift),
	.take_sum  (take_sum)
);

`default_nettype wire

//--- game_2048_top.sv
/*
 2048 move engine, flat host ports.
 Tile r*4+c sits at bits r*48+c*12 of board_in and board_out.
 Row 0 is the bottom row and column 3 the left edge.
 The host waits for done before the next load or move.
*/
`default_nettype none

module game_2048_top import game_pkg::*; #(
	parameter int SCORE_W = 20
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              load,
	input  logic [board_n*board_n*tile_w-1:0] board_in,
	input  logic                              move,
	input  logic [$bits(dir_t)-1:0]           dir,
	output logic                              busy,
	output logic                              done,
	output logic [board_n*board_n*tile_w-1:0] board_out,
	output logic [SCORE_W-1:0]                score
);

	step_if bus ();

	board_t board_in_a; // Unpacked load board
	logic   take_shift;
	logic   take_sum;

	// Flat ports to and from the board array
	always_comb begin
		for (int r = 0; r < board_n; r++) begin
			for (int c = 0; c < board_n; c++) begin
				board_in_a[r][c] = board_in[(r*board_n+c)*tile_w +: tile_w];
				board_out[(r*board_n+c)*tile_w +: tile_w] = bus.board[r][c];
			end
		end
	end

	board_regs #(
		.SCORE_W(SCORE_W)
	) regs_i (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.board_in  (board_in_a),
		.take_shift(take_shift),
		.take_sum  (take_sum),
		.busy      (busy),
		.bus       (bus.regs),
		.score     (score)
	);

	tile_shift shift_i (
		.clk(clk),
		.bus(bus.shifter)
	);

	summation sum_i (
		.clk(clk),
		.bus(bus.merger)
	);

	move_ctrl ctrl_i (
		.clk       (clk),
		.reset     (reset),
		.move      (move),
		.dir_in    (dir_t'(dir)), // Non one-hot codes rejected inside
		.bus       (bus.ctrl),
		.take_shift(take_shift),
		.take_sum  (take_sum),
		.busy      (busy),
		.done      (done)
	);

endmodule

`default_nettype wire

//--- move_ctrl.sv
/*
 Move FSM: slide until settled, merge once, slide again if gaps remain.
 Each step is a compute cycle followed by a write-back cycle.
 A move is taken only in idle and only with a one-hot direction.
 Busy falls in the cycle of the done pulse.
*/
`default_nettype none

module move_ctrl import game_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   move,
	input  dir_t   dir_in,
	step_if.ctrl   bus,
	output logic   take_shift,
	output logic   take_sum,
	output logic   busy,
	output logic   done
);

	ctrl_state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= idle;
			bus.dir <= dir_down;
		end else begin
			case (state)
				idle: begin
					if (move && $onehot(dir_in)) begin
						bus.dir <= dir_in; // Held for the whole move
						state   <= shift;
					end
				end
				shift:      state <= shift_wb; // Shift unit computing
				shift_wb:   state <= bus.shift_settled ? merge : shift;
				merge:      state <= merge_wb; // Merge unit computing
				merge_wb:   state <= bus.sum_ready ? finish : reshift;
				reshift:    state <= reshift_wb;
				reshift_wb: state <= bus.shift_settled ? finish : reshift;
				finish:     state <= idle;
				default:    state <= idle;
			endcase
		end
	end

	// Write-back strobes to the board registers
	assign take_shift = (state == shift_wb) || (state == reshift_wb);
	assign take_sum   = (state == merge_wb);

	assign busy = (state != idle) && (state != finish);
	assign done = (state == finish); // Board and score final here

endmodule

`default_nettype wire

//--- summation.sv
/*
 Merge pass of equal neighbours toward the move edge.
 The pair nearest the edge merges first and each tile merges once per pass.
 Ready is low when a tile still has a gap below it, so a slide must follow.
 Outputs are registered one cycle after the board input.
*/
`default_nettype none

module summation import game_pkg::*; (
	input  logic       clk,
	step_if.merger     bus
);

	board_t           t; // Board turned toward the edge
	logic             rdy;
	logic [pts_w-1:0] pts; // Sum of doubled values

	always_comb begin
		t   = to_edge(bus.board, bus.dir);
		rdy = 1'b1;
		pts = '0;
		for (int i = 0; i < board_n; i++) begin
			for (int j = 0; j < board_n; j++) begin
				if (t[i][j] != '0) begin
					// Upper neighbour equal, double here and clear it
					if (i != board_n-1 && t[i+1][j] == t[i][j]) begin
						t[i][j]   = t[i][j] + t[i+1][j];
						t[i+1][j] = '0;
						pts       = pts + pts_w'(t[i][j]);
					end
					if (i != 0 && t[i-1][j] == '0) begin
						rdy = 1'b0; // Gap below, needs another slide
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		bus.sum_board  <= from_edge(t, bus.dir); // Undo the turn
		bus.sum_ready  <= rdy;
		bus.sum_points <= pts;
	end

endmodule

`default_nettype wire

//--- tile_shift.sv
/*
 One slide step toward the move edge.
 Every tile moves at most one cell, so a full slide needs up to three steps.
 Outputs are registered one cycle after the board input.
*/
`default_nettype none

module tile_shift import game_pkg::*; (
	input  logic       clk,
	step_if.shifter    bus
);

	board_t t; // Board turned toward the edge
	logic   moved;

	always_comb begin
		t     = to_edge(bus.board, bus.dir);
		moved = 1'b0;
		// Bottom-up so a vacated cell is only refilled from directly above
		for (int i = 1; i < board_n; i++) begin
			for (int j = 0; j < board_n; j++) begin
				if (t[i][j] != '0 && t[i-1][j] == '0) begin
					t[i-1][j] = t[i][j]; // Drop one cell
					t[i][j]   = '0;
					moved     = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		bus.shift_board   <= from_edge(t, bus.dir); // Back to board orientation
		bus.shift_settled <= !moved;
	end

endmodule

`default_nettype wire

//--- board_regs.sv
/*
 Board and score registers.
 A host load is taken only while not busy and clears the score.
 Score wraps silently at SCORE_W bits, which must be 16 or more.
*/
`default_nettype none

module board_regs import game_pkg::*; #(
	parameter int SCORE_W = 20
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               load,
	input  board_t             board_in,
	input  logic               take_shift,
	input  logic               take_sum,
	input  logic               busy,
	step_if.regs               bus,
	output logic [SCORE_W-1:0] score
);

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.board <= '{default: '0}; // Empty board
			score     <= '0;
		end else if (load && !busy) begin
			bus.board <= board_in; // New game or test position
			score     <= '0;
		end else if (take_shift) begin
			bus.board <= bus.shift_board; // Slide result
		end else if (take_sum) begin
			bus.board <= bus.sum_board; // Merge result
			score     <= score + SCORE_W'(bus.sum_points);
		end
	end

endmodule

`default_nettype wire

//--- step_if.sv
/*
 Board and step results shared by the registers, both step units and the FSM.
*/
`default_nettype none

interface step_if import game_pkg::*; ();

	dir_t                dir; // Latched move direction
	board_t              board; // Current board
	board_t              shift_board; // One slide step applied
	logic                shift_settled; // Nothing could slide
	board_t              sum_board; // Merge pass applied
	logic                sum_ready; // Merge left no gaps
	logic [pts_w-1:0]    sum_points; // Values created by the merge

	modport regs    (output board, input shift_board, sum_board, sum_points);
	modport shifter (input board, dir, output shift_board, shift_settled);
	modport merger  (input board, dir, output sum_board, sum_ready, sum_points);
	modport ctrl    (output dir, input shift_settled, sum_ready);

endinterface

`default_nettype wire

//--- game_pkg.sv
/*
 Shared types for the 2048 move engine.
 Row 0 is the bottom row and column 3 is the left edge of the board.
 Tiles are 12 bits, so merging two 2048 tiles wraps to zero.
*/
`default_nettype none

package game_pkg;

	localparam int tile_w  = 12; // Bits per tile value, 0 is empty
	localparam int board_n = 4; // Rows and columns
	localparam int pts_w   = 16; // Points gained in one merge pass

	typedef enum logic [3:0] {
		dir_left  = 4'b1000, // Toward column 3
		dir_down  = 4'b0100, // Toward row 0
		dir_up    = 4'b0010, // Toward row 3
		dir_right = 4'b0001 // Toward column 0
	} dir_t;

	typedef enum logic [2:0] {
		idle,
		shift, // First slide phase, compute cycle
		shift_wb,
		merge,
		merge_wb,
		reshift, // Slide again after merge gaps
		reshift_wb,
		finish // Done pulse
	} ctrl_state_t;

	typedef logic [tile_w-1:0] board_t [board_n][board_n]; // [row][column]

	// Turn the board so the move edge becomes row 0
	function automatic board_t to_edge(input board_t b, input dir_t d);
		board_t r;
		for (int i = 0; i < board_n; i++) begin
			for (int j = 0; j < board_n; j++) begin
				case (d)
					dir_left:  r[i][j] = b[j][board_n-1-i]; // Left column to bottom
					dir_up:    r[i][j] = b[board_n-1-i][j]; // Flip rows
					dir_right: r[i][j] = b[board_n-1-j][i]; // Right column to bottom
					default:   r[i][j] = b[i][j]; // Down needs no turn
				endcase
			end
		end
		return r;
	endfunction

	// Inverse of to_edge
	function automatic board_t from_edge(input board_t b, input dir_t d);
		board_t r;
		for (int i = 0; i < board_n; i++) begin
			for (int j = 0; j < board_n; j++) begin
				case (d)
					dir_left:  r[i][j] = b[board_n-1-j][i];
					dir_up:    r[i][j] = b[board_n-1-i][j];
					dir_right: r[i][j] = b[j][board_n-1-i];
					default:   r[i][j] = b[i][j];
				endcase
			end
		end
		return r;
	endfunction

endpackage

`default_nettype wire
